/* Bender.yml */
package:
  name: cfg_boot

sources:
  # Packages first, then the design bottom up
  - src/cfg_params_pkg.sv
  - src/cfg_types_pkg.sv
  - src/cfg_loader.sv
  - src/cfg_apb_master.sv
  - src/cfg_addr_decode.sv
  - src/cfg_core_regs.sv
  - src/cfg_boot_top.sv

  - target: simulation
    files:
      - tb/cfg_boot_assert.sv
      - tb/cfg_boot_tb.sv

/* sim.f */
src/cfg_params_pkg.sv
src/cfg_types_pkg.sv
src/cfg_loader.sv
src/cfg_apb_master.sv
src/cfg_addr_decode.sv
src/cfg_core_regs.sv
src/cfg_boot_top.sv
tb/cfg_boot_assert.sv
tb/cfg_boot_tb.sv

/* src/cfg_addr_decode.sv */
`timescale 1ns/1ns

module cfg_addr_decode (
  input  cfg_types_pkg::cfg_addr_u                paddr_i,
  input  logic                                    psel_i,
  output logic [cfg_params_pkg::NUM_CORES-1:0]    psel_o,
  input  logic [cfg_params_pkg::NUM_CORES-1:0]    pready_vec_i,
  input  logic [cfg_params_pkg::NUM_CORES-1:0]    pslverr_vec_i,
  output logic                                    pready_o,
  output logic                                    pslverr_o
);
  import cfg_params_pkg::*;

  logic [CORE_IDX_W-1:0] core_sel;

  // **************************************************
  // Target select
  // **************************************************
  assign core_sel = paddr_i.r.core; // Core field sits in the same place in both views

  always_comb begin
    psel_o           = '0;
    psel_o[core_sel] = psel_i;
  end

  // Return path from the selected core
  assign pready_o  = pready_vec_i[core_sel];
  assign pslverr_o = pslverr_vec_i[core_sel];

endmodule

/* src/cfg_apb_master.sv */
`timescale 1ns/1ns

module cfg_apb_master (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  cfg_types_pkg::cfg_cmd_s                 cmd_i,
  input  logic                                    cmd_v_i,
  output logic                                    cmd_ready_o,
  output cfg_types_pkg::cfg_resp_s                resp_o,
  output logic                                    resp_v_o,
  output cfg_types_pkg::cfg_addr_u                paddr_o,
  output logic                                    psel_o,
  output logic                                    penable_o,
  output logic [cfg_params_pkg::DATA_WIDTH-1:0]   pwdata_o,
  input  logic                                    pready_i,
  input  logic                                    pslverr_i
);
  import cfg_types_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} state_e;

  state_e   state_r;
  cfg_cmd_s cur_r;
  cfg_cmd_s buf_r;
  logic     buf_v_r;
  logic     accept;
  logic     done;

  assign cmd_ready_o = (state_r == ST_IDLE) | ((state_r == ST_ACCESS) & ~buf_v_r);
  assign accept      = cmd_v_i & cmd_ready_o;
  assign done        = (state_r == ST_ACCESS) & pready_i; // Access completes

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
      buf_v_r <= 1'b0;
    end else begin
      case (state_r)
        ST_IDLE:   if (accept) state_r <= ST_SETUP;
        ST_SETUP:  state_r <= ST_ACCESS;
        ST_ACCESS: if (done) state_r <= (buf_v_r || accept) ? ST_SETUP : ST_IDLE;
        default:   state_r <= ST_IDLE;
      endcase
      if (state_r == ST_ACCESS) buf_v_r <= done ? 1'b0 : (buf_v_r | accept);
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE && accept) cur_r <= cmd_i;
    else if (done) cur_r <= buf_v_r ? buf_r : cmd_i; // Next in line goes straight to setup
    if (state_r == ST_ACCESS && accept && !done) buf_r <= cmd_i;
  end

  assign psel_o     = state_r != ST_IDLE;
  assign penable_o  = state_r == ST_ACCESS;
  assign paddr_o    = cur_r.addr;
  assign pwdata_o   = cur_r.data;
  assign resp_v_o   = done;
  assign resp_o.err = pslverr_i;

endmodule

/* src/cfg_boot_top.sv */
`timescale 1ns/1ns

module cfg_boot_top (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [cfg_params_pkg::MASK_W-1:0]     domain_mask_i,
  input  logic [cfg_params_pkg::NUM_CORES-1:0]  stall_i,
  input  logic [cfg_params_pkg::NUM_CORES-1:0][cfg_params_pkg::UCODE_ADDR_W-1:0] ucode_raddr_i,
  output logic [cfg_params_pkg::NUM_CORES-1:0][cfg_params_pkg::UCODE_WIDTH-1:0]  ucode_rdata_o,
  output cfg_types_pkg::core_status_s [cfg_params_pkg::NUM_CORES-1:0]           status_o,
  output logic                                  done_o,
  output logic                                  err_o
);
  import cfg_params_pkg::*;
  import cfg_types_pkg::*;

  cfg_cmd_s               cmd;
  cfg_resp_s              resp;
  cfg_addr_u              paddr;
  logic                   cmd_v, cmd_ready, resp_v;
  logic                   psel, penable, pready, pslverr;
  logic [DATA_WIDTH-1:0]  pwdata;
  logic [NUM_CORES-1:0]   psel_vec, pready_vec, pslverr_vec;

  cfg_loader u_loader (
    .clk_i, .reset_i, .domain_mask_i,
    .cmd_o(cmd), .cmd_v_o(cmd_v), .cmd_ready_i(cmd_ready),
    .resp_i(resp), .resp_v_i(resp_v), .done_o, .err_o
  );

  cfg_apb_master u_master (
    .clk_i, .reset_i,
    .cmd_i(cmd), .cmd_v_i(cmd_v), .cmd_ready_o(cmd_ready),
    .resp_o(resp), .resp_v_o(resp_v),
    .paddr_o(paddr), .psel_o(psel), .penable_o(penable), .pwdata_o(pwdata),
    .pready_i(pready), .pslverr_i(pslverr)
  );

  cfg_addr_decode u_decode (
    .paddr_i(paddr), .psel_i(psel), .psel_o(psel_vec),
    .pready_vec_i(pready_vec), .pslverr_vec_i(pslverr_vec),
    .pready_o(pready), .pslverr_o(pslverr)
  );

  // **************************************************
  // One register block per core
  // **************************************************
  for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
    cfg_core_regs u_regs (
      .clk_i, .reset_i,
      .paddr_i(paddr), .psel_i(psel_vec[i]), .penable_i(penable), .pwdata_i(pwdata),
      .stall_i(stall_i[i]), .pready_o(pready_vec[i]), .pslverr_o(pslverr_vec[i]),
      .status_o(status_o[i]),
      .ucode_raddr_i(ucode_raddr_i[i]), .ucode_rdata_o(ucode_rdata_o[i])
    );
  end

endmodule

/* src/cfg_core_regs.sv */
`timescale 1ns/1ns

module cfg_core_regs (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  cfg_types_pkg::cfg_addr_u                  paddr_i,
  input  logic                                      psel_i,
  input  logic                                      penable_i,
  input  logic [cfg_params_pkg::DATA_WIDTH-1:0]     pwdata_i,
  input  logic                                      stall_i,
  output logic                                      pready_o,
  output logic                                      pslverr_o,
  output cfg_types_pkg::core_status_s               status_o,
  input  logic [cfg_params_pkg::UCODE_ADDR_W-1:0]   ucode_raddr_i,
  output logic [cfg_params_pkg::UCODE_WIDTH-1:0]    ucode_rdata_o
);
  import cfg_params_pkg::*;
  import cfg_types_pkg::*;

  logic [UCODE_WIDTH-1:0] ucode_ram [UCODE_DEPTH];
  core_status_s           status_r;
  logic                   wr_done;
  logic                   reg_sel;
  logic                   ucode_sel;
  logic                   bad_idx;

  assign wr_done   = psel_i & penable_i & ~stall_i; // Last cycle of an access
  assign reg_sel   = paddr_i.r.dev == DEV_REG;
  assign ucode_sel = paddr_i.u.dev == DEV_UCODE;
  assign bad_idx   = reg_sel & (paddr_i.r.idx > REG_DOMAIN_MASK);

  assign pready_o  = ~stall_i; // Each stalled cycle is one wait state
  assign pslverr_o = wr_done & bad_idx;

  // **************************************************
  // Status registers
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      status_r.reset       <= 1'b1;
      status_r.freeze      <= 1'b1;
      status_r.icache_mode <= MODE_UNCACHED;
      status_r.dcache_mode <= MODE_UNCACHED;
      status_r.domain_mask <= '0;
    end else if (wr_done && reg_sel) begin
      case (paddr_i.r.idx)
        REG_RESET:       status_r.reset       <= pwdata_i[0];
        REG_FREEZE:      status_r.freeze      <= pwdata_i[0];
        REG_ICACHE_MODE: status_r.icache_mode <= pwdata_i[0];
        REG_DCACHE_MODE: status_r.dcache_mode <= pwdata_i[0];
        REG_DOMAIN_MASK: status_r.domain_mask <= pwdata_i[MASK_W-1:0];
        default: ; // Rejected with pslverr
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_done && ucode_sel) ucode_ram[paddr_i.u.idx] <= pwdata_i[UCODE_WIDTH-1:0];
  end

  assign status_o      = status_r;
  assign ucode_rdata_o = ucode_ram[ucode_raddr_i];

endmodule

/* src/cfg_loader.sv */
`timescale 1ns/1ns

module cfg_loader (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [cfg_params_pkg::MASK_W-1:0]   domain_mask_i,
  output cfg_types_pkg::cfg_cmd_s             cmd_o,
  output logic                                cmd_v_o,
  input  logic                                cmd_ready_i,
  input  cfg_types_pkg::cfg_resp_s            resp_i,
  input  logic                                resp_v_i,
  output logic                                done_o,
  output logic                                err_o
);
  import cfg_params_pkg::*;

  typedef enum logic [3:0] {
    ST_RESET_SET, ST_FREEZE_SET, ST_RESET_CLR, ST_UCODE, ST_ICACHE, ST_DCACHE,
    ST_WAIT_SYNC, ST_DOMAIN, ST_FREEZE_CLR, ST_WAIT_CREDITS, ST_DONE
  } state_e;

  state_e                   state_r;
  state_e                   step_next;
  logic [UCODE_WIDTH-1:0]   ucode_rom [UCODE_DEPTH];
  logic [CORE_IDX_W-1:0]    core_r;
  logic [UCODE_ADDR_W-1:0]  word_r;
  logic [CREDIT_W-1:0]      credits_r;
  logic [SYNC_W-1:0]        sync_r;
  logic [MASK_W-1:0]        mask_r;
  logic                     err_r;
  logic                     sending;
  logic                     fire;
  logic                     last_core;
  logic                     last_word;
  logic                     step_end;
  logic                     credits_empty;

  initial $readmemb(UCODE_FILE, ucode_rom);

  assign last_core     = core_r == CORE_IDX_W'(NUM_CORES - 1);
  assign last_word     = word_r == UCODE_ADDR_W'(UCODE_DEPTH - 1);
  assign credits_empty = credits_r == '0;
  assign sending       = state_r inside {ST_RESET_SET, ST_FREEZE_SET, ST_RESET_CLR, ST_UCODE,
                                         ST_ICACHE, ST_DCACHE, ST_DOMAIN, ST_FREEZE_CLR};
  assign cmd_v_o  = sending & (credits_r < CREDIT_W'(MAX_CREDITS)); // Credit limit
  assign fire     = cmd_v_o & cmd_ready_i;
  assign step_end = last_core & ((state_r != ST_UCODE) | last_word); // Last write of a step
  assign done_o   = state_r == ST_DONE;
  assign err_o    = err_r;

  // **************************************************
  // Command for the current step and core
  // **************************************************
  always_comb begin
    cmd_o            = '0;
    cmd_o.addr.r.core = core_r;
    cmd_o.addr.r.dev  = DEV_REG;
    step_next        = state_r;
    case (state_r)
      ST_RESET_SET: begin
        cmd_o.addr.r.idx = REG_RESET;
        cmd_o.data       = DATA_WIDTH'(1);
        step_next        = ST_FREEZE_SET;
      end
      ST_FREEZE_SET: begin
        cmd_o.addr.r.idx = REG_FREEZE;
        cmd_o.data       = DATA_WIDTH'(1);
        step_next        = ST_RESET_CLR;
      end
      ST_RESET_CLR: begin
        cmd_o.addr.r.idx = REG_RESET;
        step_next        = ST_UCODE;
      end
      ST_UCODE: begin
        cmd_o.addr.u.dev = DEV_UCODE; // Same core field, other view
        cmd_o.addr.u.idx = word_r;
        cmd_o.data       = DATA_WIDTH'(ucode_rom[word_r]);
        step_next        = ST_ICACHE;
      end
      ST_ICACHE: begin
        cmd_o.addr.r.idx = REG_ICACHE_MODE;
        cmd_o.data       = DATA_WIDTH'(MODE_NORMAL);
        step_next        = ST_DCACHE;
      end
      ST_DCACHE: begin
        cmd_o.addr.r.idx = REG_DCACHE_MODE;
        cmd_o.data       = DATA_WIDTH'(MODE_NORMAL);
        step_next        = ST_WAIT_SYNC;
      end
      ST_DOMAIN: begin
        cmd_o.addr.r.idx = REG_DOMAIN_MASK;
        cmd_o.data       = DATA_WIDTH'(mask_r);
        step_next        = ST_FREEZE_CLR;
      end
      ST_FREEZE_CLR: begin
        cmd_o.addr.r.idx = REG_FREEZE;
        step_next        = ST_WAIT_CREDITS;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= ST_RESET_SET;
      core_r    <= '0;
      word_r    <= '0;
      credits_r <= '0;
      sync_r    <= '0;
      err_r     <= 1'b0;
    end else begin
      credits_r <= credits_r + CREDIT_W'(fire) - CREDIT_W'(resp_v_i);
      if (resp_v_i && resp_i.err) err_r <= 1'b1; // Sticky
      if (fire) begin
        if (state_r == ST_UCODE && !last_word) begin
          word_r <= word_r + 1'b1;
        end else begin
          word_r <= '0;
          core_r <= last_core ? '0 : core_r + 1'b1;
        end
        if (step_end) state_r <= step_next;
      end
      case (state_r)
        ST_WAIT_SYNC: if (credits_empty) begin // Count only once all writes completed
          if (sync_r == SYNC_W'(SYNC_CYCLES - 1)) begin
            sync_r  <= '0;
            state_r <= ST_DOMAIN;
          end else begin
            sync_r <= sync_r + 1'b1;
          end
        end
        ST_WAIT_CREDITS: if (credits_empty) state_r <= ST_DONE;
        default: ;
      endcase
    end
  end

  // Mask is sampled on the way into the mask step
  always_ff @(posedge clk_i) begin
    if (state_r == ST_WAIT_SYNC) mask_r <= domain_mask_i;
  end

endmodule

/* src/cfg_params_pkg.sv */
package cfg_params_pkg;

  // **************************************************
  // Sizes
  // **************************************************
  localparam int NUM_CORES    = 4;
  localparam int CORE_IDX_W   = $clog2(NUM_CORES);
  localparam int UCODE_DEPTH  = 16;
  localparam int UCODE_ADDR_W = $clog2(UCODE_DEPTH);
  localparam int UCODE_WIDTH  = 32;
  localparam int DATA_WIDTH   = 32;
  localparam int CFG_ADDR_W   = 8;
  localparam int MASK_W       = 8;
  localparam int MAX_CREDITS  = 2;
  localparam int CREDIT_W     = $clog2(MAX_CREDITS + 1);
  localparam int SYNC_CYCLES  = 16;
  localparam int SYNC_W       = $clog2(SYNC_CYCLES);
  localparam string UCODE_FILE = "tb/ucode.mem"; // Coherence engine boot image

  // **************************************************
  // Register map and codes
  // **************************************************
  localparam int REG_IDX_W = 3;
  localparam logic [REG_IDX_W-1:0] REG_RESET       = 3'd0;
  localparam logic [REG_IDX_W-1:0] REG_FREEZE      = 3'd1;
  localparam logic [REG_IDX_W-1:0] REG_ICACHE_MODE = 3'd2;
  localparam logic [REG_IDX_W-1:0] REG_DCACHE_MODE = 3'd3;
  localparam logic [REG_IDX_W-1:0] REG_DOMAIN_MASK = 3'd4; // Highest valid index
  localparam logic DEV_REG       = 1'b0;
  localparam logic DEV_UCODE     = 1'b1;
  localparam logic MODE_UNCACHED = 1'b0;
  localparam logic MODE_NORMAL   = 1'b1;

endpackage

/* src/cfg_types_pkg.sv */
package cfg_types_pkg;

  import cfg_params_pkg::*;

  // Register view of a configuration address
  typedef struct packed {
    logic [CORE_IDX_W-1:0]                          core;
    logic                                           dev;
    logic [CFG_ADDR_W-CORE_IDX_W-1-REG_IDX_W-1:0]   pad;
    logic [REG_IDX_W-1:0]                           idx;
  } cfg_reg_addr_s;

  // Microcode view of a configuration address
  typedef struct packed {
    logic [CORE_IDX_W-1:0]                          core;
    logic                                           dev;
    logic [UCODE_ADDR_W-1:0]                        idx;
    logic [CFG_ADDR_W-CORE_IDX_W-1-UCODE_ADDR_W-1:0] pad;
  } cfg_ucode_addr_s;

  typedef union packed {
    cfg_reg_addr_s   r;
    cfg_ucode_addr_s u; // Selected when dev is DEV_UCODE
  } cfg_addr_u;

  typedef struct packed {
    cfg_addr_u              addr;
    logic [DATA_WIDTH-1:0]  data;
  } cfg_cmd_s;

  typedef struct packed {
    logic err;
  } cfg_resp_s;

  typedef struct packed {
    logic              reset;
    logic              freeze;
    logic              icache_mode;
    logic              dcache_mode;
    logic [MASK_W-1:0] domain_mask;
  } core_status_s;

endpackage

/* tb/cfg_boot_assert.sv */
`timescale 1ns/1ns

module boot_bus_checks (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pready_i,
  input  cfg_types_pkg::cfg_addr_u              paddr_i,
  input  logic [cfg_params_pkg::CREDIT_W-1:0]   credits_i,
  input  logic                                  done_i
);
  import cfg_params_pkg::*;

  int unsigned fail_count = 0; // Polled by the testbench

  // **************************************************
  // APB requester protocol
  // **************************************************
  a_setup_to_access: assert property (@(posedge clk_i) disable iff (reset_i)
    psel_i && !penable_i |=> psel_i && penable_i)
    else begin
      $error("APB setup phase not followed by access phase");
      fail_count++;
    end

  a_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    psel_i && penable_i && !pready_i |=> psel_i && penable_i && $stable(paddr_i))
    else begin
      $error("APB address or phase changed during a wait state");
      fail_count++;
    end

  // **************************************************
  // Loader credit limit and done
  // **************************************************
  a_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_i <= CREDIT_W'(MAX_CREDITS))
    else begin
      $error("Outstanding commands exceed the credit limit");
      fail_count++;
    end

  a_done_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |=> done_i)
    else begin
      $error("Boot done fell before reset");
      fail_count++;
    end

endmodule

// Loader side inputs are tied off in the master and the other way round
bind cfg_apb_master boot_bus_checks u_bus_checks (
  .clk_i(clk_i), .reset_i(reset_i), .psel_i(psel_o), .penable_i(penable_o),
  .pready_i(pready_i), .paddr_i(paddr_o), .credits_i('0), .done_i(1'b0)
);

bind cfg_loader boot_bus_checks u_bus_checks (
  .clk_i(clk_i), .reset_i(reset_i), .psel_i(1'b0), .penable_i(1'b0),
  .pready_i(1'b0), .paddr_i('0), .credits_i(credits_r), .done_i(done_o)
);

/* tb/cfg_boot_tb.sv */
`timescale 1ns/1ns

module cfg_boot_tb;
  import cfg_params_pkg::*;
  import cfg_types_pkg::*;

  localparam logic [31:0] SEED          = 32'hd7e56421;
  localparam int RESET_CYCLES           = 5;
  localparam int POST_DONE_CYCLES       = 50;
  localparam int NUM_WRITES             = NUM_CORES * (UCODE_DEPTH + 7);
  localparam int WATCHDOG_CYCLES        = NUM_WRITES * 20 + SYNC_CYCLES + RESET_CYCLES
                                          + POST_DONE_CYCLES + 2 * UCODE_DEPTH + 100;

  logic                                        clk;
  logic                                        reset;
  logic [MASK_W-1:0]                           domain_mask;
  logic [NUM_CORES-1:0]                        stall;
  logic [NUM_CORES-1:0][UCODE_ADDR_W-1:0]      ucode_raddr;
  logic [NUM_CORES-1:0][UCODE_WIDTH-1:0]       ucode_rdata;
  core_status_s [NUM_CORES-1:0]                status;
  logic                                        done;
  logic                                        err;
  logic [UCODE_WIDTH-1:0]                      ref_ucode [UCODE_DEPTH];
  logic [31:0]                                 lcg_state = SEED;

  cfg_boot_top u_dut (
    .clk_i(clk), .reset_i(reset), .domain_mask_i(domain_mask), .stall_i(stall),
    .ucode_raddr_i(ucode_raddr), .ucode_rdata_o(ucode_rdata), .status_o(status),
    .done_o(done), .err_o(err)
  );

  // **************************************************
  // Helpers and reference model
  // **************************************************
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic core_status_s reset_status();
    core_status_s s;
    s.reset       = 1'b1;
    s.freeze      = 1'b1;
    s.icache_mode = MODE_UNCACHED;
    s.dcache_mode = MODE_UNCACHED;
    s.domain_mask = '0;
    return s;
  endfunction

  function automatic core_status_s booted_status(input logic [MASK_W-1:0] mask);
    core_status_s s;
    s.reset       = 1'b0;
    s.freeze      = 1'b0;
    s.icache_mode = MODE_NORMAL;
    s.dcache_mode = MODE_NORMAL;
    s.domain_mask = mask;
    return s;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s actual=%0h expected=%0h",
               $time, name, actual, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Random wait states, about one cycle in four per core
  initial begin
    logic [31:0] rnd;
    stall = '0;
    wait (reset === 1'b0);
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < NUM_CORES; i++) begin
        rnd      = next_random();
        stall[i] = rnd[31:30] == 2'b00;
      end
    end
  end

  // Freeze may only drop once a core is fully configured
  initial begin
    forever begin
      @(negedge clk);
      if (reset === 1'b0) begin
        compare_value("err_o", err, 1'b0);
        compare_value("master assertion failures", u_dut.u_master.u_bus_checks.fail_count, 0);
        compare_value("loader assertion failures", u_dut.u_loader.u_bus_checks.fail_count, 0);
        for (int i = 0; i < NUM_CORES; i++) begin
          if (done !== 1'b1 && status[i].freeze === 1'b0)
            compare_value($sformatf("status_o[%0d] at freeze release", i), status[i],
                          booted_status(domain_mask));
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    if (done === 1'b1)
      $display("TIMEOUT: run did not finish after done_o rose");
    else
      $display("TIMEOUT: done_o never rose within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1);
  end

  // **************************************************
  // Test sequence
  // **************************************************
  initial begin
    logic [31:0] rnd;
    $readmemb("tb/ucode.mem", ref_ucode);
    reset       = 1'b1;
    ucode_raddr = '0;
    rnd         = next_random();
    domain_mask = rnd[31:24]; // Held for the whole run
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;

    @(posedge clk);
    @(negedge clk);
    compare_value("done_o", done, 1'b0);
    compare_value("err_o", err, 1'b0);
    for (int i = 0; i < NUM_CORES; i++)
      compare_value($sformatf("status_o[%0d]", i), status[i], reset_status());

    while (done !== 1'b1) @(negedge clk);
    compare_value("err_o", err, 1'b0);
    for (int i = 0; i < NUM_CORES; i++)
      compare_value($sformatf("status_o[%0d]", i), status[i], booted_status(domain_mask));

    for (int w = 0; w < UCODE_DEPTH; w++) begin
      @(posedge clk);
      #1;
      for (int c = 0; c < NUM_CORES; c++) ucode_raddr[c] = UCODE_ADDR_W'(w);
      @(negedge clk);
      for (int c = 0; c < NUM_CORES; c++)
        compare_value($sformatf("ucode_rdata_o[%0d] word %0d", c, w), ucode_rdata[c],
                      ref_ucode[w]);
    end

    repeat (POST_DONE_CYCLES) begin
      @(negedge clk);
      compare_value("done_o", done, 1'b1);
      for (int i = 0; i < NUM_CORES; i++)
        compare_value($sformatf("status_o[%0d]", i), status[i], booted_status(domain_mask));
    end

    compare_value("err_o", err, 1'b0);
    compare_value("master assertion failures", u_dut.u_master.u_bus_checks.fail_count, 0);
    compare_value("loader assertion failures", u_dut.u_loader.u_bus_checks.fail_count, 0);

    $display("sim passed");
    $finish;
  end

endmodule

/* tb/ucode.mem */
// One 32-bit coherence engine microcode word per line in binary, word 0 first
00111100000000010000000000000001
10001100001000100000000000000100
00000000010000110001000000100000
10101100011000100000000000001000
00010100010000001111111111111100
00100100100001000000000000000001
00000000100001010010100000101010
00010000101000000000000000000011
11011110101011011011111011101111
01011010010110101100001111000011
01111111000000001111111100000001
00000001001000110100010101100111
10001001101010111100110111101111
11110000111000011101001011000011
00001111000111100010110100111100
11111111111111110000000000000000
